//--- stepper_pkg.sv
package stepper_pkg;

  // Fixed machine size
  localparam int MOTOR_COUNT = 2;
  localparam int MOVE_SLOTS = 2;
  localparam int SLOT_BITS = 1;
  localparam int WORD_BITS = 64;

  // Coordinated move: header, duration, then inc and incinc per axis
  localparam int MOVE_LAST_WORD = 2 * MOTOR_COUNT + 1;

  // Command codes, top byte of a header word
  localparam logic [7:0] CMD_COORDINATED_STEP = 8'h01;
  localparam logic [7:0] CMD_MOTOR_ENABLE = 8'h0A;
  localparam logic [7:0] CMD_CLK_DIVISOR = 8'h0B;
  localparam logic [7:0] CMD_MOTORCONFIG = 8'h10;
  localparam logic [7:0] CMD_MICROSTEPPER_CONFIG = 8'h16;
  localparam logic [7:0] CMD_CHARGEPUMP = 8'h1A;
  localparam logic [7:0] CMD_BRIDGEINVERT = 8'h1B;
  localparam logic [7:0] CMD_API_VERSION = 8'hFE;

  localparam logic [7:0] VERSION_MAJOR = 8'd1;
  localparam logic [7:0] VERSION_MINOR = 8'd2;
  localparam logic [7:0] VERSION_PATCH = 8'd3;

  // Reset values of the configuration registers
  localparam logic [2:0] DEF_MICROSTEPS = 3'd2;
  localparam logic [7:0] DEF_CURRENT = 8'd140;
  localparam logic [9:0] DEF_OFFTIME = 10'd810;
  localparam logic [7:0] DEF_BLANKTIME = 8'd27;
  localparam logic [9:0] DEF_FASTDECAY = 10'd706;
  localparam logic [7:0] DEF_MIN_ON = 8'd54;
  localparam logic [10:0] DEF_CUR_THRESHOLD = 11'd1024;
  localparam logic [7:0] DEF_CHARGEPUMP = 8'd91;
  localparam logic DEF_BRIDGE_INVERT = 1'b0;
  localparam logic [7:0] DEF_CLK_DIVISOR = 8'd40;

  // Microstepper config word, low bit of each field
  localparam int MS_OFFTIME_LSB = 37;
  localparam int MS_BLANKTIME_LSB = 29;
  localparam int MS_FASTDECAY_LSB = 19;
  localparam int MS_MIN_ON_LSB = 11;
  localparam int MS_CUR_THRESHOLD_LSB = 0;

  typedef struct packed {
    logic [7:0] cmd;
    logic [WORD_BITS-9:0] payload;
  } spi_header_t;

  // A received word is either raw data or a command header
  typedef union packed {
    logic [WORD_BITS-1:0] raw;
    spi_header_t hdr;
  } spi_word_u;

endpackage

//--- spi_word.sv
`timescale 1ns/100ps

module spi_word (
  input  logic CLK,
  input  logic resetn,
  input  logic sck,
  input  logic cs,
  input  logic copi,
  input  logic [stepper_pkg::WORD_BITS-1:0] send_data,
  output logic cipo,
  output logic word_received,
  output logic [stepper_pkg::WORD_BITS-1:0] word_data
);
  import stepper_pkg::*;

  logic [1:0] sck_sync;
  logic [1:0] cs_sync;
  logic [1:0] copi_sync;
  logic sck_prev;
  logic sck_rise;
  logic sck_fall;
  logic cs_active;
  logic [5:0] bit_count;
  logic [WORD_BITS-1:0] shift_in;
  logic [WORD_BITS-1:0] shift_out;
  logic [WORD_BITS-1:0] rx_next;

  assign sck_rise = sck_sync[1] & ~sck_prev;
  assign sck_fall = ~sck_sync[1] & sck_prev;
  assign cs_active = ~cs_sync[1];
  assign rx_next = {shift_in[WORD_BITS-2:0], copi_sync[1]};
  assign cipo = shift_out[WORD_BITS-1];

  // Pin synchronizers, CS idles high
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      sck_sync <= 2'b00;
      cs_sync <= 2'b11;
      copi_sync <= 2'b00;
      sck_prev <= 1'b0;
    end else begin
      sck_sync <= {sck_sync[0], sck};
      cs_sync <= {cs_sync[0], cs};
      copi_sync <= {copi_sync[0], copi};
      sck_prev <= sck_sync[1];
    end
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      bit_count <= '0;
      word_received <= 1'b0;
      shift_out <= '0;
    end else begin
      word_received <= 1'b0;
      if (!cs_active) begin
        bit_count <= '0;
      end else if (sck_rise) begin
        // Counter wraps to zero on the 64th bit
        bit_count <= bit_count + 1'b1;
        if (bit_count == '1) begin
          word_received <= 1'b1;
        end
      end
      // Between words the reply is reloaded so late updates still go out
      if (!cs_active || bit_count == '0) begin
        shift_out <= send_data;
      end else if (sck_fall) begin
        shift_out <= {shift_out[WORD_BITS-2:0], 1'b0};
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (cs_active && sck_rise) begin
      shift_in <= rx_next;
      if (bit_count == '1) begin
        word_data <= rx_next;
      end
    end
  end

endmodule

//--- command_decoder.sv
`timescale 1ns/100ps

module command_decoder (
  input  logic CLK,
  input  logic resetn,
  input  logic word_received,
  input  logic [stepper_pkg::WORD_BITS-1:0] word_data,
  input  logic [63:0] encoder_count,
  input  logic [stepper_pkg::MOVE_SLOTS-1:0] slot_finished,
  output logic [stepper_pkg::WORD_BITS-1:0] send_data,
  output logic move_wr,
  output logic [stepper_pkg::SLOT_BITS-1:0] wr_slot,
  output logic [stepper_pkg::MOTOR_COUNT-1:0] move_dir,
  output logic [63:0] move_duration,
  output logic [stepper_pkg::MOTOR_COUNT-1:0][63:0] move_inc,
  output logic [stepper_pkg::MOTOR_COUNT-1:0][63:0] move_incinc,
  output logic [stepper_pkg::MOVE_SLOTS-1:0] slot_ready,
  output logic [stepper_pkg::MOTOR_COUNT-1:0] enable,
  output logic [7:0] clock_divisor,
  output logic [2:0] microsteps,
  output logic [7:0] current,
  output logic [9:0] config_offtime,
  output logic [7:0] config_blanktime,
  output logic [9:0] config_fastdecay_threshold,
  output logic [7:0] config_minimum_on_time,
  output logic [10:0] config_current_threshold,
  output logic [7:0] config_chargepump_period,
  output logic config_invert_highside,
  output logic config_invert_lowside
);
  import stepper_pkg::*;

  spi_word_u rx;
  logic word_q;
  logic [7:0] msg_cmd;
  logic [7:0] word_count;
  logic [63:0] encoder_store;
  logic in_message;
  logic is_move;
  logic hdr_take;
  logic data_take;

  assign rx = word_data;
  assign in_message = (msg_cmd == CMD_COORDINATED_STEP) || (msg_cmd == CMD_API_VERSION);
  assign is_move = (msg_cmd == CMD_COORDINATED_STEP);
  assign hdr_take = word_q & ~in_message;
  assign data_take = word_q & in_message;

  // Move staging and encoder snapshot
  always_ff @(posedge CLK) begin
    if (hdr_take && rx.hdr.cmd == CMD_COORDINATED_STEP) begin
      move_dir <= rx.hdr.payload[MOTOR_COUNT-1:0];
      encoder_store <= encoder_count;
    end
    if (data_take && is_move) begin
      if (word_count == 8'd1) begin
        move_duration <= rx.raw;
      end
      for (int a = 0; a < MOTOR_COUNT; a++) begin
        if (word_count == 8'(2 * a + 2)) begin
          move_inc[a] <= rx.raw;
        end
        if (word_count == 8'(2 * a + 3)) begin
          move_incinc[a] <= rx.raw;
        end
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      word_q <= 1'b0;
      msg_cmd <= '0;
      word_count <= '0;
      send_data <= '0;
      move_wr <= 1'b0;
      wr_slot <= '0;
      slot_ready <= '0;
      enable <= '0;
      clock_divisor <= DEF_CLK_DIVISOR;
      microsteps <= DEF_MICROSTEPS;
      current <= DEF_CURRENT;
      config_offtime <= DEF_OFFTIME;
      config_blanktime <= DEF_BLANKTIME;
      config_fastdecay_threshold <= DEF_FASTDECAY;
      config_minimum_on_time <= DEF_MIN_ON;
      config_current_threshold <= DEF_CUR_THRESHOLD;
      config_chargepump_period <= DEF_CHARGEPUMP;
      config_invert_highside <= DEF_BRIDGE_INVERT;
      config_invert_lowside <= DEF_BRIDGE_INVERT;
    end else begin
      word_q <= word_received;
      move_wr <= 1'b0;
      // Slot goes pending the cycle after its data is stored
      if (move_wr) begin
        slot_ready[wr_slot] <= ~slot_finished[wr_slot];
        wr_slot <= wr_slot + 1'b1;
      end
      if (word_q) begin
        send_data <= '0;
        if (!in_message) begin
          msg_cmd <= rx.hdr.cmd;
          word_count <= 8'd1;
          case (rx.hdr.cmd)
            CMD_MOTOR_ENABLE: enable <= rx.hdr.payload[MOTOR_COUNT-1:0];
            CMD_CLK_DIVISOR: clock_divisor <= rx.hdr.payload[7:0];
            CMD_MOTORCONFIG: begin
              current <= rx.hdr.payload[15:8];
              microsteps <= rx.hdr.payload[2:0];
            end
            CMD_MICROSTEPPER_CONFIG: begin
              config_offtime <= rx.hdr.payload[MS_OFFTIME_LSB +: 10];
              config_blanktime <= rx.hdr.payload[MS_BLANKTIME_LSB +: 8];
              config_fastdecay_threshold <= rx.hdr.payload[MS_FASTDECAY_LSB +: 10];
              config_minimum_on_time <= rx.hdr.payload[MS_MIN_ON_LSB +: 8];
              config_current_threshold <= rx.hdr.payload[MS_CUR_THRESHOLD_LSB +: 11];
            end
            CMD_CHARGEPUMP: config_chargepump_period <= rx.hdr.payload[7:0];
            CMD_BRIDGEINVERT: begin
              config_invert_highside <= rx.hdr.payload[1];
              config_invert_lowside <= rx.hdr.payload[0];
            end
            CMD_API_VERSION: begin
              send_data <= {40'd0, VERSION_MAJOR, VERSION_MINOR, VERSION_PATCH};
            end
            default: ;
          endcase
        end else if (is_move) begin
          word_count <= word_count + 1'b1;
          // Snapshot goes out while the host sends the incinc word
          if (word_count >= 8'd2 && !word_count[0]) begin
            send_data <= encoder_store;
          end
          if (word_count == 8'(MOVE_LAST_WORD)) begin
            msg_cmd <= '0;
            word_count <= '0;
            move_wr <= 1'b1;
          end
        end else begin
          // Trailing word of a two-word exchange
          msg_cmd <= '0;
          word_count <= '0;
        end
      end
    end
  end

endmodule

//--- move_sequencer.sv
`timescale 1ns/100ps

module move_sequencer (
  input  logic CLK,
  input  logic resetn,
  input  logic [7:0] clock_divisor,
  input  logic move_wr,
  input  logic [stepper_pkg::SLOT_BITS-1:0] wr_slot,
  input  logic [stepper_pkg::MOTOR_COUNT-1:0] move_dir,
  input  logic [63:0] move_duration,
  input  logic [stepper_pkg::MOTOR_COUNT-1:0][63:0] move_inc,
  input  logic [stepper_pkg::MOTOR_COUNT-1:0][63:0] move_incinc,
  input  logic [stepper_pkg::MOVE_SLOTS-1:0] slot_ready,
  output logic [stepper_pkg::MOVE_SLOTS-1:0] slot_finished,
  output logic [stepper_pkg::MOTOR_COUNT-1:0] dir,
  output logic dda_tick,
  output logic loading,
  output logic executing,
  output logic [stepper_pkg::MOTOR_COUNT-1:0][63:0] cur_inc,
  output logic [stepper_pkg::MOTOR_COUNT-1:0][63:0] cur_incinc,
  output logic buffer_dtr,
  output logic move_done
);
  import stepper_pkg::*;

  logic [MOTOR_COUNT-1:0] slot_dir [MOVE_SLOTS];
  logic [63:0] slot_duration [MOVE_SLOTS];
  logic [MOTOR_COUNT-1:0][63:0] slot_inc [MOVE_SLOTS];
  logic [MOTOR_COUNT-1:0][63:0] slot_incinc [MOVE_SLOTS];
  logic [SLOT_BITS-1:0] rd_slot;
  logic [7:0] div_count;
  logic [63:0] ticks_left;
  logic move_idle;
  logic pending;
  logic in_move;

  // Slot is pending while its toggle bits differ
  assign pending = slot_ready[rd_slot] ^ slot_finished[rd_slot];
  assign loading = move_idle & pending;
  assign in_move = ~move_idle & pending;
  // No ticks reach the DDAs on the cycle a move ends
  assign executing = in_move & (ticks_left != '0);
  assign buffer_dtr = ~&(slot_ready ^ slot_finished);

  assign dir = slot_dir[rd_slot];
  assign cur_inc = slot_inc[rd_slot];
  assign cur_incinc = slot_incinc[rd_slot];

  always_ff @(posedge CLK) begin
    if (move_wr) begin
      slot_dir[wr_slot] <= move_dir;
      slot_duration[wr_slot] <= move_duration;
      slot_inc[wr_slot] <= move_inc;
      slot_incinc[wr_slot] <= move_incinc;
    end
  end

  // Tick every clock_divisor cycles, divisor 0 acts as 1
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      div_count <= '0;
      dda_tick <= 1'b0;
    end else if ({1'b0, div_count} + 9'd1 >= {1'b0, clock_divisor}) begin
      div_count <= '0;
      dda_tick <= 1'b1;
    end else begin
      div_count <= div_count + 1'b1;
      dda_tick <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      rd_slot <= '0;
      ticks_left <= '0;
      move_idle <= 1'b1;
      slot_finished <= '0;
      move_done <= 1'b0;
    end else if (loading) begin
      ticks_left <= slot_duration[rd_slot];
      move_idle <= 1'b0;
    end else if (in_move) begin
      if (ticks_left == '0) begin
        // Hand the slot back and move on
        move_idle <= 1'b1;
        move_done <= ~move_done;
        slot_finished[rd_slot] <= ~slot_finished[rd_slot];
        rd_slot <= rd_slot + 1'b1;
      end else if (dda_tick) begin
        ticks_left <= ticks_left - 1'b1;
      end
    end
  end

endmodule

//--- dda_axis.sv
`timescale 1ns/100ps

module dda_axis (
  input  logic CLK,
  input  logic resetn,
  input  logic dda_tick,
  input  logic loading,
  input  logic executing,
  input  logic [63:0] inc,
  input  logic [63:0] incinc,
  output logic step
);

  // 32.32 fixed point position and velocity
  logic [63:0] accumulator;
  logic [63:0] velocity;
  logic [63:0] acc_next;
  logic advance;

  assign advance = dda_tick & executing;
  assign acc_next = accumulator + velocity;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      accumulator <= '0;
      velocity <= '0;
      step <= 1'b0;
    end else begin
      step <= 1'b0;
      if (loading) begin
        accumulator <= '0;
        velocity <= inc;
      end else if (advance) begin
        // Position uses the velocity from before this tick
        accumulator <= acc_next;
        velocity <= velocity + incinc;
        // One pulse whenever the whole-step part moves up
        step <= (acc_next[63:32] > accumulator[63:32]);
      end
    end
  end

endmodule

//--- stepper_controller.sv
`timescale 1ns/100ps

module stepper_controller (
  input  logic CLK,
  input  logic resetn,
  input  logic sck,
  input  logic cs,
  input  logic copi,
  input  logic [63:0] encoder_count,
  output logic cipo,
  output logic [stepper_pkg::MOTOR_COUNT-1:0] step,
  output logic [stepper_pkg::MOTOR_COUNT-1:0] dir,
  output logic [stepper_pkg::MOTOR_COUNT-1:0] enable,
  output logic [7:0] clock_divisor,
  output logic [2:0] microsteps,
  output logic [7:0] current,
  output logic [9:0] config_offtime,
  output logic [7:0] config_blanktime,
  output logic [9:0] config_fastdecay_threshold,
  output logic [7:0] config_minimum_on_time,
  output logic [10:0] config_current_threshold,
  output logic [7:0] config_chargepump_period,
  output logic config_invert_highside,
  output logic config_invert_lowside,
  output logic buffer_dtr,
  output logic move_done
);
  import stepper_pkg::*;

  logic [WORD_BITS-1:0] word_data;
  logic [WORD_BITS-1:0] send_data;
  logic word_received;
  logic move_wr;
  logic [SLOT_BITS-1:0] wr_slot;
  logic [MOTOR_COUNT-1:0] move_dir;
  logic [63:0] move_duration;
  logic [MOTOR_COUNT-1:0][63:0] move_inc;
  logic [MOTOR_COUNT-1:0][63:0] move_incinc;
  logic [MOVE_SLOTS-1:0] slot_ready;
  logic [MOVE_SLOTS-1:0] slot_finished;
  logic dda_tick;
  logic loading;
  logic executing;
  logic [MOTOR_COUNT-1:0][63:0] cur_inc;
  logic [MOTOR_COUNT-1:0][63:0] cur_incinc;

  spi_word u_spi_word (
    .CLK(CLK), .resetn(resetn), .sck(sck), .cs(cs), .copi(copi),
    .send_data(send_data), .cipo(cipo), .word_received(word_received),
    .word_data(word_data)
  );

  command_decoder u_command_decoder (
    .CLK(CLK), .resetn(resetn), .word_received(word_received), .word_data(word_data),
    .encoder_count(encoder_count), .slot_finished(slot_finished), .send_data(send_data),
    .move_wr(move_wr), .wr_slot(wr_slot), .move_dir(move_dir),
    .move_duration(move_duration), .move_inc(move_inc), .move_incinc(move_incinc),
    .slot_ready(slot_ready), .enable(enable), .clock_divisor(clock_divisor),
    .microsteps(microsteps), .current(current), .config_offtime(config_offtime),
    .config_blanktime(config_blanktime),
    .config_fastdecay_threshold(config_fastdecay_threshold),
    .config_minimum_on_time(config_minimum_on_time),
    .config_current_threshold(config_current_threshold),
    .config_chargepump_period(config_chargepump_period),
    .config_invert_highside(config_invert_highside),
    .config_invert_lowside(config_invert_lowside)
  );

  move_sequencer u_move_sequencer (
    .CLK(CLK), .resetn(resetn), .clock_divisor(clock_divisor), .move_wr(move_wr),
    .wr_slot(wr_slot), .move_dir(move_dir), .move_duration(move_duration),
    .move_inc(move_inc), .move_incinc(move_incinc), .slot_ready(slot_ready),
    .slot_finished(slot_finished), .dir(dir), .dda_tick(dda_tick), .loading(loading),
    .executing(executing), .cur_inc(cur_inc), .cur_incinc(cur_incinc),
    .buffer_dtr(buffer_dtr), .move_done(move_done)
  );

  // One DDA per axis
  for (genvar i = 0; i < MOTOR_COUNT; i++) begin : g_axis
    dda_axis u_dda_axis (
      .CLK(CLK), .resetn(resetn), .dda_tick(dda_tick), .loading(loading),
      .executing(executing), .inc(cur_inc[i]), .incinc(cur_incinc[i]), .step(step[i])
    );
  end

endmodule

//--- tb_stepper_controller.sv
`timescale 1ns/100ps

module tb_stepper_controller;
  import stepper_pkg::*;

  // Generous bound on the summed length of all tests
  localparam int CYCLE_LIMIT = 200000;

  logic CLK;
  logic resetn;
  logic sck;
  logic cs;
  logic copi;
  logic [63:0] encoder_count;
  logic cipo;
  logic [MOTOR_COUNT-1:0] step;
  logic [MOTOR_COUNT-1:0] dir;
  logic [MOTOR_COUNT-1:0] enable;
  logic [7:0] clock_divisor;
  logic [2:0] microsteps;
  logic [7:0] current;
  logic [9:0] config_offtime;
  logic [7:0] config_blanktime;
  logic [9:0] config_fastdecay_threshold;
  logic [7:0] config_minimum_on_time;
  logic [10:0] config_current_threshold;
  logic [7:0] config_chargepump_period;
  logic config_invert_highside;
  logic config_invert_lowside;
  logic buffer_dtr;
  logic move_done;

  int errors;
  int tests_passed;
  int tests_failed;
  int cycles;
  int done_count;
  logic done_prev;
  logic [2:0] move_idx;
  int unsigned steps_axis0 [8];
  int unsigned steps_axis1 [8];
  logic [77:0] cfg_all;

  assign cfg_all = {enable, clock_divisor, microsteps, current, config_offtime,
                    config_blanktime, config_fastdecay_threshold, config_minimum_on_time,
                    config_current_threshold, config_chargepump_period,
                    config_invert_highside, config_invert_lowside};

  stepper_controller UUT (.*);

  always #2 CLK = ~CLK;

  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: run stopped after %0d cycles without finishing", cycles);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // Step pulses binned per move at each move_done toggle
  always @(negedge CLK) begin
    if (resetn) begin
      if (step[0]) begin
        steps_axis0[move_idx] = steps_axis0[move_idx] + 1;
      end
      if (step[1]) begin
        steps_axis1[move_idx] = steps_axis1[move_idx] + 1;
      end
      if (move_done != done_prev) begin
        done_count = done_count + 1;
        move_idx = move_idx + 3'd1;
      end
    end
    done_prev = move_done;
  end

  task automatic wait_clk(input int n);
    repeat (n) @(posedge CLK);
    #0.5;
  endtask

  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    assert (got === exp) else begin
      $display("error: %0s expected %0h got %0h", name, exp, got);
      errors++;
    end
  endtask

  task automatic end_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      tests_passed++;
      $display("test %0s: ok", name);
    end else begin
      tests_failed++;
      $display("test %0s: failed", name);
    end
  endtask

  function automatic logic [63:0] make_header(input logic [7:0] cmd, input logic [55:0] payload);
    spi_word_u w;
    w.hdr.cmd = cmd;
    w.hdr.payload = payload;
    return w.raw;
  endfunction

  function automatic logic [55:0] rand_payload();
    logic [63:0] r;
    r = {$urandom, $urandom};
    return r[55:0];
  endfunction

  // Whole steps after dur ticks with velocity growing from inc by incinc
  function automatic logic [63:0] expected_steps(input logic [63:0] inc,
                                                 input logic [63:0] incinc,
                                                 input logic [63:0] dur);
    logic [127:0] sum;
    logic [127:0] vel;
    sum = '0;
    vel = {64'd0, inc};
    for (longint k = 0; k < longint'(dur); k++) begin
      sum = sum + vel;
      vel = vel + {64'd0, incinc};
    end
    return sum[95:32];
  endfunction

  // Mode 0 host that sets copi while SCK is low and takes cipo just before the rise
  task automatic spi_xfer(input logic [63:0] tx, output logic [63:0] rx);
    for (int i = 63; i >= 0; i--) begin
      copi = tx[i];
      wait_clk(4);
      rx[i] = cipo;
      sck = 1'b1;
      wait_clk(4);
      sck = 1'b0;
    end
    wait_clk(16);
  endtask

  task automatic cs_begin();
    cs = 1'b0;
    wait_clk(4);
  endtask

  task automatic cs_end();
    cs = 1'b1;
    wait_clk(8);
  endtask

  task automatic send_cmd(input logic [7:0] cmd, input logic [55:0] payload);
    logic [63:0] rx;
    cs_begin();
    spi_xfer(make_header(cmd, payload), rx);
    cs_end();
  endtask

  // Encoder changes right after the header so the snapshot is distinguishable
  task automatic send_move(input logic [1:0] dirs, input logic [63:0] dur,
                           input logic [1:0][63:0] inc, input logic [1:0][63:0] incinc,
                           output logic [63:0] snap_exp, output logic [63:0] snap_got);
    logic [63:0] rx;
    encoder_count = {$urandom, $urandom};
    snap_exp = encoder_count;
    cs_begin();
    spi_xfer(make_header(CMD_COORDINATED_STEP, {54'd0, dirs}), rx);
    encoder_count = {$urandom, $urandom};
    spi_xfer(dur, rx);
    spi_xfer(inc[0], rx);
    spi_xfer(incinc[0], snap_got);
    spi_xfer(inc[1], rx);
    spi_xfer(incinc[1], rx);
    cs_end();
  endtask

  task automatic wait_moves(input int target);
    while (done_count < target) begin
      wait_clk(1);
    end
  endtask

  task automatic check_steps(input int idx, input logic [1:0][63:0] inc,
                             input logic [1:0][63:0] incinc, input logic [63:0] dur);
    check_value("step[0] count", steps_axis0[idx[2:0]], expected_steps(inc[0], incinc[0], dur));
    check_value("step[1] count", steps_axis1[idx[2:0]], expected_steps(inc[1], incinc[1], dur));
  endtask

  initial begin
    logic [55:0] p;
    logic [63:0] rx;
    logic [77:0] cfg_before;
    logic [1:0][63:0] inc;
    logic [1:0][63:0] incinc;
    logic [1:0][63:0] inc_b;
    logic [1:0][63:0] incinc_b;
    logic [1:0] dirs;
    logic [63:0] snap_exp;
    logic [63:0] snap_got;
    int e0;
    int base;

    void'($urandom(32'h3cf7_fec3));
    CLK = 1'b0;
    resetn = 1'b0;
    sck = 1'b0;
    cs = 1'b1;
    copi = 1'b0;
    encoder_count = '0;
    errors = 0;
    tests_passed = 0;
    tests_failed = 0;
    cycles = 0;
    done_count = 0;
    done_prev = 1'b0;
    move_idx = '0;
    for (int i = 0; i < 8; i++) begin
      steps_axis0[i] = 0;
      steps_axis1[i] = 0;
    end
    repeat (10) @(posedge CLK);
    #0.5;
    resetn = 1'b1;
    wait_clk(2);

    e0 = errors;
    check_value("enable", enable, 0);
    check_value("step", step, 0);
    check_value("move_done", move_done, 0);
    check_value("buffer_dtr", buffer_dtr, 1);
    check_value("clock_divisor", clock_divisor, 40);
    check_value("microsteps", microsteps, 2);
    check_value("current", current, 140);
    check_value("config_offtime", config_offtime, 810);
    check_value("config_blanktime", config_blanktime, 27);
    check_value("config_fastdecay_threshold", config_fastdecay_threshold, 706);
    check_value("config_minimum_on_time", config_minimum_on_time, 54);
    check_value("config_current_threshold", config_current_threshold, 1024);
    check_value("config_chargepump_period", config_chargepump_period, 91);
    check_value("config_invert_highside", config_invert_highside, 0);
    check_value("config_invert_lowside", config_invert_lowside, 0);
    end_test("reset state", e0);

    e0 = errors;
    p = rand_payload();
    send_cmd(CMD_MOTOR_ENABLE, p);
    check_value("enable", enable, p[1:0]);
    p = rand_payload();
    send_cmd(CMD_CLK_DIVISOR, p);
    check_value("clock_divisor", clock_divisor, p[7:0]);
    p = rand_payload();
    send_cmd(CMD_MOTORCONFIG, p);
    check_value("current", current, p[15:8]);
    check_value("microsteps", microsteps, p[2:0]);
    p = rand_payload();
    send_cmd(CMD_MICROSTEPPER_CONFIG, p);
    check_value("config_offtime", config_offtime, p[46:37]);
    check_value("config_blanktime", config_blanktime, p[36:29]);
    check_value("config_fastdecay_threshold", config_fastdecay_threshold, p[28:19]);
    check_value("config_minimum_on_time", config_minimum_on_time, p[18:11]);
    check_value("config_current_threshold", config_current_threshold, p[10:0]);
    p = rand_payload();
    send_cmd(CMD_CHARGEPUMP, p);
    check_value("config_chargepump_period", config_chargepump_period, p[7:0]);
    p = rand_payload();
    send_cmd(CMD_BRIDGEINVERT, p);
    check_value("config_invert_highside", config_invert_highside, p[1]);
    check_value("config_invert_lowside", config_invert_lowside, p[0]);
    // Code 0x55 is not decoded
    cfg_before = cfg_all;
    send_cmd(8'h55, rand_payload());
    check_value("config outputs", cfg_all, cfg_before);
    end_test("configuration commands", e0);

    e0 = errors;
    cs_begin();
    spi_xfer(make_header(CMD_API_VERSION, 56'd0), rx);
    spi_xfer(64'd0, rx);
    cs_end();
    check_value("version reply", rx, 64'h0000_0000_0001_0203);
    end_test("api version", e0);

    e0 = errors;
    send_cmd(CMD_CLK_DIVISOR, 56'd3);
    base = done_count;
    send_move(2'b01, 64'd5, '0, '0, snap_exp, snap_got);
    check_value("encoder snapshot", snap_got, snap_exp);
    wait_moves(base + 1);
    end_test("encoder snapshot", e0);

    for (int v = 0; v < 2; v++) begin
      e0 = errors;
      for (int a = 0; a < 2; a++) begin
        inc[a] = {32'd0, 2'b01, 30'($urandom)};
        incinc[a] = (v == 1) ? {42'd0, 22'($urandom)} : 64'd0;
      end
      dirs = 2'($urandom);
      base = done_count;
      send_move(dirs, 64'd60, inc, incinc, snap_exp, snap_got);
      check_value("dir", dir, dirs);
      wait_moves(base + 1);
      wait_clk(4);
      check_steps(base, inc, incinc, 64'd60);
      end_test((v == 1) ? "move stepping with incinc" : "move stepping constant rate", e0);
    end

    e0 = errors;
    send_cmd(CMD_CLK_DIVISOR, 56'd4);
    for (int a = 0; a < 2; a++) begin
      inc[a] = {32'd0, 2'b01, 30'($urandom)};
      incinc[a] = {44'd0, 20'($urandom)};
      inc_b[a] = {32'd0, 2'b01, 30'($urandom)};
      incinc_b[a] = {44'd0, 20'($urandom)};
    end
    base = done_count;
    send_move(2'($urandom), 64'd1000, inc, incinc, snap_exp, snap_got);
    check_value("buffer_dtr", buffer_dtr, 1);
    send_move(2'($urandom), 64'd1000, inc_b, incinc_b, snap_exp, snap_got);
    // First move still running, so both slots are pending
    check_value("buffer_dtr", buffer_dtr, 0);
    check_value("move_done toggles", done_count - base, 0);
    wait_moves(base + 2);
    // Window of one full move, so a spurious third move would show
    wait_clk(4 * 1000 + 200);
    check_value("move_done toggles", done_count - base, 2);
    check_value("buffer_dtr", buffer_dtr, 1);
    check_steps(base, inc, incinc, 64'd1000);
    check_steps(base + 1, inc_b, incinc_b, 64'd1000);
    end_test("buffering and flow control", e0);

    $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- stepper_controller.f
stepper_pkg.sv
spi_word.sv
command_decoder.sv
move_sequencer.sv
dda_axis.sv
stepper_controller.sv
tb_stepper_controller.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench, then scan the log for the failure line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_stepper_controller \
  -f stepper_controller.f -o tb_sim > build.log 2>&1 || { echo "build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 || { echo "simulation crashed"; exit 1; }
grep -q "TESTBENCH FAILED" sim.log && { echo "simulation failed"; exit 1; } || exit 0
